// File: include/dvi_params.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// DVI transmitter constants
// symbol length, lane count, clock-lane word and the four TMDS control codes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef DVI_PARAMS_SVH
`define DVI_PARAMS_SVH

// one TMDS symbol is ten bits, sent LSB first
`define DVI_TMDS_BITS 10

// three data lanes carry blue, green and red in that order
`define DVI_LANES 3

// clock lane word with five ones in bits 0 to 4 and five zeros above
`define DVI_CLOCK_PATTERN 10'b0000011111

// control symbols sent during blanking, indexed by the pair {c1, c0}
`define DVI_CTRL_00 10'b1101010100
`define DVI_CTRL_01 10'b0010101011
`define DVI_CTRL_10 10'b0101010100
`define DVI_CTRL_11 10'b1010101011

`endif

// File: rtl/dvi_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// DVI transmitter types
// pixel components, control pairs, TMDS symbols and the disparity counter
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "dvi_params.svh"

package dvi_pkg;

    // one 8-bit colour component of a pixel
    typedef logic [7:0] pixel_byte_t;

    // control pair {c1, c0} sent on a channel while data-enable is low
    typedef logic [1:0] tmds_ctrl_t;

    // one encoded symbol as it goes out on a lane
    typedef logic [`DVI_TMDS_BITS-1:0] tmds_word_t;

    // running disparity, ones minus zeros sent so far on a channel
    // the DVI algorithm keeps it well inside this range
    typedef logic signed [4:0] disparity_t;

endpackage

`default_nettype wire

// File: rtl/dvi_pixel_capture.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// DVI pixel capture
// samples RGB, data-enable and syncs once per pixel strobe
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module dvi_pixel_capture
(
    input  wire                   clk_pixel_x10,
    input  wire                   rst_n,
    input  wire                   pixel_strobe,
    input  wire                   de,
    input  wire                   hsync,
    input  wire                   vsync,
    input  wire dvi_pkg::pixel_byte_t red,
    input  wire dvi_pkg::pixel_byte_t green,
    input  wire dvi_pkg::pixel_byte_t blue,
    output dvi_pkg::pixel_byte_t  cap_red,
    output dvi_pkg::pixel_byte_t  cap_green,
    output dvi_pkg::pixel_byte_t  cap_blue,
    output logic                  cap_de,
    output logic                  cap_hsync,
    output logic                  cap_vsync
);

    // the colour bytes are only looked at while cap_de is high,
    // so they simply follow the source on every strobe
    always_ff @(posedge clk_pixel_x10)
    begin
        if (pixel_strobe)
        begin
            cap_red   <= red;
            cap_green <= green;
            cap_blue  <= blue;
        end
    end

    // control signals start out as blanking with both syncs low
    always_ff @(posedge clk_pixel_x10)
    begin
        if (!rst_n)
        begin
            cap_de    <= 1'b0;
            cap_hsync <= 1'b0;
            cap_vsync <= 1'b0;
        end
        else if (pixel_strobe)
        begin
            // the source changes its inputs only after a strobe, so
            // this sample is stable and all three encoders share it
            cap_de    <= de;
            cap_hsync <= hsync;
            cap_vsync <= vsync;
        end
    end

endmodule

`default_nettype wire

// File: rtl/tmds_channel_encoder.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// TMDS channel encoder
// DVI 1.0 8b/10b transition-minimised coding with running-disparity
// DC balance, and control symbols while data-enable is low
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "dvi_params.svh"

module tmds_channel_encoder
(
    input  wire                   clk_pixel_x10,
    input  wire                   rst_n,
    input  wire                   pixel_strobe,
    input  wire dvi_pkg::pixel_byte_t data_in,
    input  wire                   de,
    input  wire dvi_pkg::tmds_ctrl_t  ctrl,
    output dvi_pkg::tmds_word_t   symbol
);

    logic [3:0]          ones_data;
    logic [3:0]          ones_qm;
    logic                use_xnor;
    logic [8:0]          q_m;
    dvi_pkg::disparity_t q_balance;
    dvi_pkg::disparity_t disparity;
    dvi_pkg::disparity_t disparity_next;
    dvi_pkg::tmds_word_t data_word;
    dvi_pkg::tmds_word_t ctrl_word;

    function automatic logic [3:0] count_ones(input logic [7:0] value);
        logic [3:0] total;
        total = '0;
        for (int i = 0; i < 8; i++)
            total = total + 4'(value[i]);
        return total;
    endfunction

    // stage one picks XOR or XNOR chaining, whichever gives fewer transitions
    always_comb
    begin
        ones_data = count_ones(data_in);
        use_xnor  = (ones_data > 4'd4) || (ones_data == 4'd4 && !data_in[0]);
        q_m[0]    = data_in[0];
        for (int i = 1; i < 8; i++)
            q_m[i] = use_xnor ? ~(q_m[i-1] ^ data_in[i]) : (q_m[i-1] ^ data_in[i]);
        // bit 8 is set for XOR and clear for XNOR
        q_m[8]    = !use_xnor;
        ones_qm   = count_ones(q_m[7:0]);
        // balance of the chained byte, ones minus zeros, is 2 * (ones - 4)
        q_balance = (dvi_pkg::disparity_t'({1'b0, ones_qm}) - dvi_pkg::disparity_t'(4)) <<< 1;
    end

    // stage two decides on inversion to pull the running disparity toward zero
    always_comb
    begin
        if (disparity == 0 || q_balance == 0)
        begin
            // no bias either way, so bit 8 alone decides the polarity
            data_word      = {~q_m[8], q_m[8], (q_m[8] ? q_m[7:0] : ~q_m[7:0])};
            disparity_next = q_m[8] ? disparity + q_balance : disparity - q_balance;
        end
        else if ((disparity > 0 && q_balance > 0) || (disparity < 0 && q_balance < 0))
        begin
            // the byte would push further the same way, send it inverted
            data_word      = {1'b1, q_m[8], ~q_m[7:0]};
            disparity_next = disparity - q_balance
                           + (q_m[8] ? dvi_pkg::disparity_t'(2) : dvi_pkg::disparity_t'(0));
        end
        else
        begin
            // the byte already counters the bias, send it as it is
            data_word      = {1'b0, q_m[8], q_m[7:0]};
            disparity_next = disparity + q_balance
                           - (q_m[8] ? dvi_pkg::disparity_t'(0) : dvi_pkg::disparity_t'(2));
        end
    end

    // blanking symbols, ctrl is {c1, c0}
    always_comb
    begin
        case (ctrl)
            2'b00:   ctrl_word = `DVI_CTRL_00;
            2'b01:   ctrl_word = `DVI_CTRL_01;
            2'b10:   ctrl_word = `DVI_CTRL_10;
            default: ctrl_word = `DVI_CTRL_11;
        endcase
    end

    // the symbol is held for the whole ten-bit slot between strobes
    always_ff @(posedge clk_pixel_x10)
    begin
        if (!rst_n)
        begin
            symbol    <= `DVI_CTRL_00;
            disparity <= '0;
        end
        else if (pixel_strobe)
        begin
            if (de)
            begin
                symbol    <= data_word;
                disparity <= disparity_next;
            end
            else
            begin
                // control symbols are balanced, and each active line
                // restarts its disparity count from zero
                symbol    <= ctrl_word;
                disparity <= '0;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/tmds_serializer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// TMDS serializer
// divides the fast clock by ten into the pixel strobe, then shifts three
// data lanes and the clock lane out LSB first through output flops
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "dvi_params.svh"

module tmds_serializer
(
    input  wire                   clk_pixel_x10,
    input  wire                   rst_n,
    input  wire dvi_pkg::tmds_word_t symbol0,
    input  wire dvi_pkg::tmds_word_t symbol1,
    input  wire dvi_pkg::tmds_word_t symbol2,
    output logic                  pixel_strobe,
    output logic [`DVI_LANES-1:0] tmds,
    output logic                  tmds_clock
);

    logic [3:0]          phase;
    dvi_pkg::tmds_word_t lane_load  [`DVI_LANES];
    dvi_pkg::tmds_word_t lane_shift [`DVI_LANES];
    dvi_pkg::tmds_word_t clock_shift;

    assign lane_load[0] = symbol0;
    assign lane_load[1] = symbol1;
    assign lane_load[2] = symbol2;

    // phase runs 0 to 9, so the first strobe comes on the tenth cycle out of reset
    assign pixel_strobe = (phase == 4'(`DVI_TMDS_BITS - 1));

    always_ff @(posedge clk_pixel_x10)
    begin
        if (!rst_n || pixel_strobe)
            phase <= '0;
        else
            phase <= phase + 4'd1;
    end

    // the strobe cycle loads new words just as the last bit of the old ones
    // has moved into the output flops
    always_ff @(posedge clk_pixel_x10)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < `DVI_LANES; i++)
                lane_shift[i] <= '0;
            clock_shift <= '0;
        end
        else if (pixel_strobe)
        begin
            for (int i = 0; i < `DVI_LANES; i++)
                lane_shift[i] <= lane_load[i];
            clock_shift <= `DVI_CLOCK_PATTERN;
        end
        else
        begin
            for (int i = 0; i < `DVI_LANES; i++)
                lane_shift[i] <= lane_shift[i] >> 1;
            // loaded together with the data, so its ones sit on bits 0 to 4
            clock_shift <= {clock_shift[0], clock_shift[`DVI_TMDS_BITS-1:1]};
        end
    end

    // one flop per lane keeps the pad timing clean, bit 0 leaves the cycle after a load
    always_ff @(posedge clk_pixel_x10)
    begin
        if (!rst_n)
        begin
            tmds       <= '0;
            tmds_clock <= 1'b0;
        end
        else
        begin
            for (int i = 0; i < `DVI_LANES; i++)
                tmds[i] <= lane_shift[i][0];
            tmds_clock <= clock_shift[0];
        end
    end

endmodule

`default_nettype wire

// File: rtl/dvi_transmitter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// DVI transmitter top level
// pixel capture, three TMDS encoders and the lane serializer on one clock
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "dvi_params.svh"

module dvi_transmitter
(
    input  wire                       clk_pixel_x10,
    input  wire                       rst_n,
    input  wire dvi_pkg::pixel_byte_t red,
    input  wire dvi_pkg::pixel_byte_t green,
    input  wire dvi_pkg::pixel_byte_t blue,
    input  wire                       de,
    input  wire                       hsync,
    input  wire                       vsync,
    output wire [`DVI_LANES-1:0]      tmds,
    output wire                       tmds_clock,
    output wire                       pixel_tick
);

    dvi_pkg::pixel_byte_t cap_red;
    dvi_pkg::pixel_byte_t cap_green;
    dvi_pkg::pixel_byte_t cap_blue;
    logic                 cap_de;
    logic                 cap_hsync;
    logic                 cap_vsync;
    dvi_pkg::tmds_word_t  symbol0;
    dvi_pkg::tmds_word_t  symbol1;
    dvi_pkg::tmds_word_t  symbol2;

    dvi_pixel_capture u_capture (
        .clk_pixel_x10 (clk_pixel_x10), .rst_n (rst_n), .pixel_strobe (pixel_tick),
        .de (de), .hsync (hsync), .vsync (vsync),
        .red (red), .green (green), .blue (blue),
        .cap_red (cap_red), .cap_green (cap_green), .cap_blue (cap_blue),
        .cap_de (cap_de), .cap_hsync (cap_hsync), .cap_vsync (cap_vsync)
    );

    // channel 0 is blue and carries the syncs as {vsync, hsync}
    tmds_channel_encoder u_enc0 (
        .clk_pixel_x10 (clk_pixel_x10), .rst_n (rst_n), .pixel_strobe (pixel_tick),
        .data_in (cap_blue), .de (cap_de), .ctrl ({cap_vsync, cap_hsync}),
        .symbol (symbol0)
    );

    tmds_channel_encoder u_enc1 (
        .clk_pixel_x10 (clk_pixel_x10), .rst_n (rst_n), .pixel_strobe (pixel_tick),
        .data_in (cap_green), .de (cap_de), .ctrl (2'b00), .symbol (symbol1)
    );

    tmds_channel_encoder u_enc2 (
        .clk_pixel_x10 (clk_pixel_x10), .rst_n (rst_n), .pixel_strobe (pixel_tick),
        .data_in (cap_red), .de (cap_de), .ctrl (2'b00), .symbol (symbol2)
    );

    // the serializer's strobe paces the whole core and the video source
    tmds_serializer u_serializer (
        .clk_pixel_x10 (clk_pixel_x10), .rst_n (rst_n),
        .symbol0 (symbol0), .symbol1 (symbol1), .symbol2 (symbol2),
        .pixel_strobe (pixel_tick), .tmds (tmds), .tmds_clock (tmds_clock)
    );

endmodule

`default_nettype wire

// File: testbench/dvi_transmitter_asserts.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// DVI transmitter assertions
// pixel strobe spacing, clock-lane shape and clock-lane level in reset
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module dvi_transmitter_asserts
(
    input wire clk_pixel_x10,
    input wire rst_n,
    input wire pixel_tick,
    input wire tmds_clock
);

    logic [4:0] since_tick;
    logic       seen_tick;
    logic       reset_held = 1'b0;

    // cycles since the last pixel_tick, counted once the first one is seen
    always_ff @(posedge clk_pixel_x10)
    begin
        if (!rst_n)
        begin
            since_tick <= '0;
            seen_tick  <= 1'b0;
        end
        else if (pixel_tick)
        begin
            since_tick <= '0;
            seen_tick  <= 1'b1;
        end
        else if (since_tick != 5'd31)
            since_tick <= since_tick + 5'd1;
    end

    // set when the previous edge already saw reset and cleared the output flops
    always @(posedge clk_pixel_x10)
        reset_held <= !rst_n;

    tick_spacing: assert property (@(posedge clk_pixel_x10) disable iff (!rst_n)
        seen_tick |-> (pixel_tick == (since_tick == 5'd9)))
        else $error("pixel_tick is not followed by exactly nine quiet cycles");

    clock_shape: assert property (@(posedge clk_pixel_x10) disable iff (!rst_n)
        $rose(tmds_clock) |-> ##5 $fell(tmds_clock) ##5 $rose(tmds_clock))
        else $error("tmds_clock is not five cycles high then five low");

    clock_in_reset: assert property (@(posedge clk_pixel_x10)
        (!rst_n && reset_held) |-> !tmds_clock)
        else $error("tmds_clock is high during reset");

endmodule

bind dvi_transmitter dvi_transmitter_asserts u_asserts (
    .clk_pixel_x10 (clk_pixel_x10), .rst_n (rst_n),
    .pixel_tick (pixel_tick), .tmds_clock (tmds_clock)
);

`default_nettype wire

// File: testbench/tb_dvi_transmitter.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// DVI transmitter testbench
// plays blanking and active video into the core, deserialises the lanes
// and checks every symbol against a reference TMDS encoder
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "dvi_params.svh"

module tb_dvi_transmitter;

    // bytes with extreme or lopsided balance for the inversion logic
    localparam logic [7:0] extreme_bytes [8] =
        '{8'h00, 8'hFF, 8'h0F, 8'hF0, 8'h55, 8'hAA, 8'hFF, 8'hFF};

    logic                 clk_pixel_x10;
    logic                 rst_n;
    dvi_pkg::pixel_byte_t red;
    dvi_pkg::pixel_byte_t green;
    dvi_pkg::pixel_byte_t blue;
    logic                 de;
    logic                 hsync;
    logic                 vsync;
    wire [`DVI_LANES-1:0] tmds;
    wire                  tmds_clock;
    wire                  pixel_tick;

    // pixels are queued as {de, vsync, hsync, red, green, blue}
    logic [26:0]          script_q [$];
    logic [26:0]          expect_q [$];
    dvi_pkg::disparity_t  model_disp [`DVI_LANES];
    int                   line_disp [`DVI_LANES];
    int                   words_checked;
    int                   cycle_count;
    int                   cycle_limit;
    logic                 prev_clock;
    int                   low_run;
    int                   bit_pos;
    bit                   aligned;
    int                   since_reset;
    int                   last_tick;
    dvi_pkg::tmds_word_t  lane_word [`DVI_LANES];
    dvi_pkg::tmds_word_t  clock_word;

    dvi_transmitter DUT (
        .clk_pixel_x10 (clk_pixel_x10), .rst_n (rst_n),
        .red (red), .green (green), .blue (blue),
        .de (de), .hsync (hsync), .vsync (vsync),
        .tmds (tmds), .tmds_clock (tmds_clock), .pixel_tick (pixel_tick)
    );

    initial
    begin
        clk_pixel_x10 = 1'b0;
        forever #2 clk_pixel_x10 = ~clk_pixel_x10;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Test failures found");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_symbol(input string name, input dvi_pkg::tmds_word_t got,
                                input dvi_pkg::tmds_word_t exp);
        if (got !== exp)
            abort_run($sformatf("Error at %0t: %s is %b, expected %b", $time, name, got, exp));
    endtask

    task automatic check_clock_word(input string name, input dvi_pkg::tmds_word_t got,
                                    input dvi_pkg::tmds_word_t exp);
        if (got !== exp)
            abort_run($sformatf("Error at %0t: %s is %b, expected %b", $time, name, got, exp));
    endtask

    task automatic check_level(input string name, input logic got, input logic exp);
        if (got !== exp)
            abort_run($sformatf("Error at %0t: %s is %b, expected %b", $time, name, got, exp));
    endtask

    // all lanes sit at zero until the first loaded word comes out
    task automatic check_idle();
        for (int lane = 0; lane < `DVI_LANES; lane++)
            check_level($sformatf("tmds[%0d]", lane), tmds[lane], 1'b0);
        check_level("tmds_clock", tmds_clock, 1'b0);
    endtask

    // DVI 1.0 encoder written from the spec flow chart with integer counts
    function automatic dvi_pkg::tmds_word_t tmds_encode_ref(input dvi_pkg::pixel_byte_t d,
        input logic active, input dvi_pkg::tmds_ctrl_t ctrl, inout dvi_pkg::disparity_t disp);
        logic [8:0]          qm;
        int                  ones_d;
        int                  ones_q;
        int                  zeros_q;
        int                  cnt;
        dvi_pkg::tmds_word_t word;
        if (!active)
        begin
            disp = '0;
            case (ctrl)
                2'b00:   return `DVI_CTRL_00;
                2'b01:   return `DVI_CTRL_01;
                2'b10:   return `DVI_CTRL_10;
                default: return `DVI_CTRL_11;
            endcase
        end
        ones_d = $countones(d);
        qm[0]  = d[0];
        if (ones_d > 4 || (ones_d == 4 && !d[0]))
        begin
            for (int i = 1; i < 8; i++)
                qm[i] = qm[i-1] ~^ d[i];
            qm[8] = 1'b0;
        end
        else
        begin
            for (int i = 1; i < 8; i++)
                qm[i] = qm[i-1] ^ d[i];
            qm[8] = 1'b1;
        end
        ones_q  = $countones(qm[7:0]);
        zeros_q = 8 - ones_q;
        cnt     = int'(disp);
        if (cnt == 0 || ones_q == zeros_q)
        begin
            word = {~qm[8], qm[8], (qm[8] ? qm[7:0] : ~qm[7:0])};
            cnt  = qm[8] ? cnt + (ones_q - zeros_q) : cnt + (zeros_q - ones_q);
        end
        else if ((cnt > 0 && ones_q > zeros_q) || (cnt < 0 && zeros_q > ones_q))
        begin
            word = {1'b1, qm[8], ~qm[7:0]};
            cnt  = cnt + (qm[8] ? 2 : 0) + (zeros_q - ones_q);
        end
        else
        begin
            word = {1'b0, qm[8], qm[7:0]};
            cnt  = cnt - (qm[8] ? 0 : 2) + (ones_q - zeros_q);
        end
        disp = dvi_pkg::disparity_t'(cnt);
        return word;
    endfunction

    // one full word per lane has arrived, match it to the oldest queued pixel
    task automatic compare_received_words();
        logic [26:0]          item;
        logic                 exp_de;
        logic                 exp_vs;
        logic                 exp_hs;
        dvi_pkg::pixel_byte_t lane_byte [`DVI_LANES];
        dvi_pkg::tmds_ctrl_t  lane_ctrl;
        dvi_pkg::tmds_word_t  expected;
        check_clock_word("tmds_clock", clock_word, `DVI_CLOCK_PATTERN);
        if (expect_q.size() == 0)
            abort_run("a word came out on the lanes with no pixel queued for it");
        item = expect_q.pop_front();
        {exp_de, exp_vs, exp_hs, lane_byte[2], lane_byte[1], lane_byte[0]} = item;
        for (int lane = 0; lane < `DVI_LANES; lane++)
        begin
            // only channel 0 carries the syncs
            lane_ctrl = (lane == 0) ? {exp_vs, exp_hs} : 2'b00;
            expected  = tmds_encode_ref(lane_byte[lane], exp_de, lane_ctrl, model_disp[lane]);
            // running ones minus zeros of the words this lane really sent since blanking
            if (exp_de)
                line_disp[lane] += 2 * $countones(lane_word[lane]) - `DVI_TMDS_BITS;
            else
                line_disp[lane] = 0;
            if (line_disp[lane] > 10 || line_disp[lane] < -10)
                abort_run($sformatf("disparity on channel %0d left the range of 10", lane));
            check_symbol($sformatf("tmds[%0d]", lane), lane_word[lane], expected);
        end
        words_checked++;
    endtask

    task automatic add_pixel(input logic pix_de, input logic vs, input logic hs,
        input dvi_pkg::pixel_byte_t r, input dvi_pkg::pixel_byte_t g,
        input dvi_pkg::pixel_byte_t b);
        script_q.push_back({pix_de, vs, hs, r, g, b});
    endtask

    // colour bytes during blanking are noise that the encoders must ignore
    task automatic add_blanking(input logic vs, input logic hs, input int count);
        repeat (count)
            add_pixel(1'b0, vs, hs, 8'($urandom()), 8'($urandom()), 8'($urandom()));
    endtask

    task automatic add_random_active(input int count);
        repeat (count)
            add_pixel(1'b1, 1'b0, 1'b0, 8'($urandom()), 8'($urandom()), 8'($urandom()));
    endtask

    // lanes are sampled at the falling edge, half a cycle clear of the output flops
    always @(negedge clk_pixel_x10)
    begin
        if (!rst_n)
        begin
            check_idle();
            low_run     = 0;
            bit_pos     = -1;
            aligned     = 1'b0;
            since_reset = 0;
            last_tick   = 0;
            prev_clock  = 1'b0;
        end
        else
        begin
            since_reset++;
            // the first tick lands on cycle 10, as if one came at cycle 0
            if (pixel_tick)
            begin
                if (since_reset - last_tick != 10)
                    abort_run($sformatf("pixel_tick came %0d cycles after the last one, not 10",
                                        since_reset - last_tick));
                last_tick = since_reset;
            end
            if (tmds_clock && !prev_clock && low_run >= 5)
            begin
                bit_pos = 0;
                aligned = 1'b1;
            end
            else if (bit_pos < 0)
            begin
                if (aligned)
                    abort_run("the clock lane did not start a new word right after the last one");
                check_idle();
            end
            if (bit_pos >= 0)
            begin
                for (int lane = 0; lane < `DVI_LANES; lane++)
                    lane_word[lane][bit_pos] = tmds[lane];
                clock_word[bit_pos] = tmds_clock;
                bit_pos++;
                if (bit_pos == `DVI_TMDS_BITS)
                begin
                    compare_received_words();
                    bit_pos = -1;
                end
            end
            low_run    = tmds_clock ? 0 : low_run + 1;
            prev_clock = tmds_clock;
        end
    end

    always @(posedge clk_pixel_x10)
    begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count > cycle_limit)
            abort_run($sformatf("the run hung and hit the limit of %0d cycles", cycle_limit));
    end

    initial
    begin
        logic [26:0] item;
        int          next_idx;
        void'($urandom(32'h57f5092e));
        rst_n         = 1'b0;
        de            = 1'b0;
        hsync         = 1'b0;
        vsync         = 1'b0;
        red           = '0;
        green         = '0;
        blue          = '0;
        words_checked = 0;
        cycle_count   = 0;
        cycle_limit   = 0;
        for (int lane = 0; lane < `DVI_LANES; lane++)
        begin
            model_disp[lane] = '0;
            line_disp[lane]  = 0;
        end
        // two words of encoder reset state, then the idle pixel held through reset
        repeat (3) expect_q.push_back(27'd0);

        // every sync pair on channel 0, then a random active line
        for (int s = 0; s < 4; s++)
            add_blanking(s[1], s[0], 3);
        add_random_active(40);
        add_blanking(1'b0, 1'b1, 4);
        for (int i = 0; i < 24; i++)
            add_pixel(1'b1, 1'b0, 1'b0, extreme_bytes[i % 8], extreme_bytes[(i + 3) % 8],
                      extreme_bytes[(i + 5) % 8]);
        add_blanking(1'b1, 1'b0, 4);
        add_random_active(16);
        add_blanking(1'b0, 1'b0, 3);
        cycle_limit = 20 * (script_q.size() + 3) + 200;

        repeat (3) @(posedge clk_pixel_x10);
        rst_n <= 1'b1;
        next_idx = 0;
        item     = '0;
        // after the script the last pixel stays on the inputs and is queued again
        while (words_checked < script_q.size() + 3)
        begin
            @(posedge clk_pixel_x10);
            if (pixel_tick)
            begin
                if (next_idx < script_q.size())
                begin
                    item = script_q[next_idx];
                    next_idx++;
                end
                {de, vsync, hsync, red, green, blue} <= item;
                expect_q.push_back(item);
            end
        end
        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
+incdir+include
rtl/dvi_pkg.sv
rtl/dvi_pixel_capture.sv
rtl/tmds_channel_encoder.sv
rtl/tmds_serializer.sv
rtl/dvi_transmitter.sv
testbench/dvi_transmitter_asserts.sv
testbench/tb_dvi_transmitter.sv

// File: Makefile
# Verilator build and run of the DVI transmitter testbench

VERILATOR ?= verilator
TOP       ?= tb_dvi_transmitter
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "All tests passed!" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
